/* source/isa_pkg.sv */
// RV32I encodings plus the custom-0 warp-control opcode; F, M and 64-bit word forms are not covered
package isa_pkg;

    localparam int XLEN = 32;

    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;
    typedef logic [11:0]     csr_addr_t;

    // Major opcodes, bits 6:0
    typedef enum logic [6:0] {
        OP_I     = 7'b0010011,
        OP_R     = 7'b0110011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_B     = 7'b1100011,
        OP_L     = 7'b0000011,
        OP_S     = 7'b0100011,
        OP_FENCE = 7'b0001111,
        OP_SYS   = 7'b1110011,
        OP_EXT1  = 7'b0001011  // custom-0, warp control
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Branch unit ops, system calls and returns included
    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    typedef enum logic [3:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN, SFU_BAR, SFU_PRED,
        SFU_CSRRW, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    // Loads are {0,funct3}, stores {1,funct3}; 4'hf is free in RV32
    localparam logic [3:0] LSU_FENCE = 4'hf;

endpackage

/* source/decode_pkg.sv */
// Pipeline-side types for 4 warps of 4 threads; op_type carries a 4-bit isa_pkg opcode of the unit
package decode_pkg;

    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;

    typedef logic [$clog2(NUM_WARPS)-1:0] wid_t;
    typedef logic [NUM_THREADS-1:0]       tmask_t;
    typedef logic [3:0]                   op_type_t;

    typedef enum logic [1:0] {
        EX_ALU,
        EX_LSU,
        EX_SFU
    } ex_type_e;

    typedef struct packed {
        wid_t            wid;
        tmask_t          tmask;
        isa_pkg::word_t  pc;
        isa_pkg::instr_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        ex_type_e          ex_type;
        op_type_t          op_type;
        logic              is_br;
        logic              use_pc;
        logic              use_imm;
        isa_pkg::word_t    imm;
        logic              wb;    // rd written and rd != x0
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
    } uop_body_t;

    typedef struct packed {
        wid_t           wid;
        tmask_t         tmask;
        isa_pkg::word_t pc;
        uop_body_t      body;
    } uop_t;

    typedef struct packed {
        wid_t wid;
        logic is_wstall;
    } sched_msg_t;

endpackage

/* source/imm_gen.sv */
// Pure combinational; imm_i gives the zero-extended shamt only for OP_I shifts
module imm_gen (
    input  isa_pkg::instr_t instr,
    output isa_pkg::word_t  imm_i,
    output isa_pkg::word_t  imm_s,
    output isa_pkg::word_t  imm_b,
    output isa_pkg::word_t  imm_u,
    output isa_pkg::word_t  imm_j
);

    logic is_shift;

    // SLLI / SRLI / SRAI
    assign is_shift = (instr[6:0] == isa_pkg::OP_I) && (instr[13:12] == 2'b01);

    always_comb begin
        if (is_shift) begin
            imm_i = {27'b0, instr[24:20]};
        end else begin
            imm_i = {{20{instr[31]}}, instr[31:20]};
        end
    end

    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

/* source/op_tables.sv */
// Combinational funct lookups; unused branch funct3 and unknown system codes fall back to EQ / ECALL
module op_tables (
    input  isa_pkg::instr_t  instr,
    output isa_pkg::alu_op_e alu_op,
    output isa_pkg::br_op_e  br_op,
    output isa_pkg::br_op_e  sys_op
);

    logic [2:0] funct3;
    logic       alt;       // funct7 bit 5

    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    always_comb begin
        case (funct3)
            3'h0: alu_op = (instr[5] && alt) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD; // R form only
            3'h1: alu_op = isa_pkg::ALU_SLL;
            3'h2: alu_op = isa_pkg::ALU_SLT;
            3'h3: alu_op = isa_pkg::ALU_SLTU;
            3'h4: alu_op = isa_pkg::ALU_XOR;
            3'h5: alu_op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            3'h6: alu_op = isa_pkg::ALU_OR;
            default: alu_op = isa_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1: br_op = isa_pkg::BR_NE;
            3'h4: br_op = isa_pkg::BR_LT;
            3'h5: br_op = isa_pkg::BR_GE;
            3'h6: br_op = isa_pkg::BR_LTU;
            3'h7: br_op = isa_pkg::BR_GEU;
            default: br_op = isa_pkg::BR_EQ;
        endcase
    end

    // funct12 of the SYSTEM opcode with funct3 zero
    always_comb begin
        case (instr[31:20])
            12'h001: sys_op = isa_pkg::BR_EBREAK;
            12'h002: sys_op = isa_pkg::BR_URET;
            12'h102: sys_op = isa_pkg::BR_SRET;
            12'h302: sys_op = isa_pkg::BR_MRET;
            default: sys_op = isa_pkg::BR_ECALL;
        endcase
    end

endmodule

/* source/instr_decoder.sv */
// RV32I plus warp-control decode; unknown opcodes become an ALU op with no registers and no wb
module instr_decoder (
    input  isa_pkg::instr_t      instr,
    output decode_pkg::uop_body_t body,
    output logic                 is_wstall
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              use_rd;
    isa_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    isa_pkg::alu_op_e  alu_op;
    isa_pkg::br_op_e   br_op;
    isa_pkg::br_op_e   sys_op;

    assign opcode = isa_pkg::opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    imm_gen u_imm_gen (
        .instr (instr),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_u (imm_u),
        .imm_j (imm_j)
    );

    op_tables u_op_tables (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op)
    );

    always_comb begin
        body         = '0;
        body.ex_type = decode_pkg::EX_ALU;
        use_rd       = 1'b0;
        is_wstall    = 1'b0;

        case (opcode)
            isa_pkg::OP_I: begin
                body.op_type = alu_op;
                body.use_imm = 1'b1;
                body.imm     = imm_i;
                body.rs1     = rs1;
                use_rd       = 1'b1;
            end
            isa_pkg::OP_R: begin
                body.op_type = alu_op;
                body.rs1     = rs1;
                body.rs2     = rs2;
                use_rd       = 1'b1;
            end
            isa_pkg::OP_LUI, isa_pkg::OP_AUIPC: begin
                body.op_type = instr[5] ? isa_pkg::ALU_LUI : isa_pkg::ALU_AUIPC;
                body.use_pc  = ~instr[5];
                body.use_imm = 1'b1;
                body.imm     = imm_u;
                use_rd       = 1'b1;
            end
            isa_pkg::OP_JAL, isa_pkg::OP_JALR: begin
                body.op_type = instr[3] ? isa_pkg::BR_JAL : isa_pkg::BR_JALR;
                body.is_br   = 1'b1;
                body.use_pc  = instr[3];
                body.use_imm = 1'b1;
                body.imm     = instr[3] ? imm_j : imm_i;
                body.rs1     = instr[3] ? '0 : rs1;
                use_rd       = 1'b1;
                is_wstall    = 1'b1;
            end
            isa_pkg::OP_B: begin
                body.op_type = br_op;
                body.is_br   = 1'b1;
                body.use_pc  = 1'b1;
                body.use_imm = 1'b1;
                body.imm     = imm_b;
                body.rs1     = rs1;
                body.rs2     = rs2;
                is_wstall    = 1'b1;
            end
            isa_pkg::OP_L, isa_pkg::OP_S: begin
                body.ex_type = decode_pkg::EX_LSU;
                body.op_type = {instr[5], funct3}; // bit 3 marks a store
                body.use_imm = 1'b1;
                body.imm     = instr[5] ? imm_s : imm_i;
                body.rs1     = rs1;
                body.rs2     = instr[5] ? rs2 : '0;
                use_rd       = ~instr[5];
            end
            isa_pkg::OP_FENCE: begin
                body.ex_type = decode_pkg::EX_LSU;
                body.op_type = isa_pkg::LSU_FENCE;
            end
            isa_pkg::OP_SYS: begin
                use_rd    = 1'b1;
                is_wstall = 1'b1;
                if (funct3[1:0] != 2'b00) begin
                    body.ex_type    = decode_pkg::EX_SFU;
                    body.op_type    = (funct3[1:0] == 2'b01) ? isa_pkg::SFU_CSRRW :
                                      (funct3[1:0] == 2'b10) ? isa_pkg::SFU_CSRRS :
                                                               isa_pkg::SFU_CSRRC;
                    body.use_imm    = funct3[2];
                    body.imm[11:0]  = isa_pkg::csr_addr_t'(instr[31:20]);
                    if (funct3[2]) begin
                        body.imm[16:12] = rs1; // uimm form
                    end else begin
                        body.rs1 = rs1;
                    end
                end else begin
                    body.op_type = sys_op;
                    body.is_br   = 1'b1;
                    body.use_pc  = 1'b1;
                    body.use_imm = 1'b1;
                    body.imm     = isa_pkg::word_t'(4);
                end
            end
            isa_pkg::OP_EXT1: begin
                if (funct7 == 7'h00 && funct3 <= 3'h5) begin
                    body.ex_type = decode_pkg::EX_SFU;
                    body.op_type = {1'b0, funct3}; // TMC..PRED follow funct3
                    body.rs1     = rs1;
                    body.rs2     = (funct3 == 3'h1 || funct3 >= 3'h4) ? rs2 : '0;
                    use_rd       = (funct3 == 3'h2); // SPLIT
                    is_wstall    = 1'b1;
                end
            end
            default: ;
        endcase

        body.rd = use_rd ? rd : '0;
        body.wb = use_rd && (rd != '0);
    end

endmodule

/* source/decode_pipe_reg.sv */
// One-entry valid/ready stage; accepts while empty or draining, so full rate needs uop_ready high
module decode_pipe_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  decode_pkg::fetch_pkt_t fetch,
    input  decode_pkg::uop_body_t  body,
    input  logic                   is_wstall,
    output logic                   uop_valid,
    output decode_pkg::uop_t       uop,
    input  logic                   uop_ready,
    output logic                   sched_valid,
    output decode_pkg::sched_msg_t sched
);

    logic accept;

    assign fetch_ready = ~uop_valid || uop_ready;
    assign accept      = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            uop_valid <= 1'b0;
        end else if (fetch_ready) begin
            uop_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop.wid   <= fetch.wid;
            uop.tmask <= fetch.tmask;
            uop.pc    <= fetch.pc;
            uop.body  <= body;
        end
    end

    // Scheduler hears about the packet in its accept cycle
    assign sched_valid     = accept;
    assign sched.wid       = fetch.wid;
    assign sched.is_wstall = is_wstall;

endmodule

/* source/decode_top.sv */
// Decode stage top; one cycle from fetch accept to uop_valid, scheduler pulse in the accept cycle
module decode_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  decode_pkg::fetch_pkt_t fetch,
    output logic                   uop_valid,
    input  logic                   uop_ready,
    output decode_pkg::uop_t       uop,
    output logic                   sched_valid,
    output decode_pkg::sched_msg_t sched
);

    decode_pkg::uop_body_t body;
    logic                  is_wstall;

    instr_decoder u_instr_decoder (
        .instr     (fetch.instr),
        .body      (body),
        .is_wstall (is_wstall)
    );

    decode_pipe_reg u_decode_pipe_reg (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .body        (body),
        .is_wstall   (is_wstall),
        .uop_valid   (uop_valid),
        .uop         (uop),
        .uop_ready   (uop_ready),
        .sched_valid (sched_valid),
        .sched       (sched)
    );

endmodule

/* bench/decode_chk.sv */
// Protocol and decode assertions for decode_top; fail_count is read back by the testbench
module decode_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   fetch_valid,
    input logic                   fetch_ready,
    input decode_pkg::fetch_pkt_t fetch,
    input logic                   uop_valid,
    input logic                   uop_ready,
    input decode_pkg::uop_t       uop,
    input logic                   sched_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    a_reset_empty: assert property (@(posedge clk) reset |=> !uop_valid)
        else begin $error("uop_valid high after a reset edge"); fail_count++; end

    // Held output under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (reset)
        uop_valid && !uop_ready |=> uop_valid && $stable(uop))
        else begin $error("uop changed while stalled"); fail_count++; end

    // Accept when fetch is valid and the stage is empty or draining
    a_sched: assert property (@(posedge clk) disable iff (reset)
        sched_valid == (fetch_valid && (!uop_valid || uop_ready)))
        else begin $error("sched_valid does not match the accept"); fail_count++; end

    a_no_x0: assert property (@(posedge clk) disable iff (reset)
        uop_valid |-> !(uop.body.wb && uop.body.rd == 5'd0))
        else begin $error("writeback to x0"); fail_count++; end

    a_fields: assert property (@(posedge clk) disable iff (reset)
        fetch_valid && fetch_ready |=> uop_valid && uop.pc == $past(fetch.pc)
            && uop.wid == $past(fetch.wid) && uop.tmask == $past(fetch.tmask))
        else begin $error("uop fields differ from the accepted packet"); fail_count++; end

endmodule

bind decode_top decode_chk u_chk (.*);

/* bench/decode_tb.sv */
// Self-checking bench; expects a one-cycle decode stage and counts the failures of the bound checker
module decode_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   fetch_valid;
    logic                   fetch_ready;
    decode_pkg::fetch_pkt_t fetch;
    logic                   uop_valid;
    logic                   uop_ready;
    decode_pkg::uop_t       uop;
    logic                   sched_valid;
    decode_pkg::sched_msg_t sched;

    decode_pkg::uop_t exp_q[$];
    decode_pkg::uop_t exp_head;
    string            test_name;
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               err_mark = 0;

    always #10 clk = ~clk;

    decode_top DUT (.*);

    function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic alt, input logic r);
        case (f3)
            3'h0: return (r && alt) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
            3'h1: return isa_pkg::ALU_SLL;
            3'h2: return isa_pkg::ALU_SLT;
            3'h3: return isa_pkg::ALU_SLTU;
            3'h4: return isa_pkg::ALU_XOR;
            3'h5: return alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            3'h6: return isa_pkg::ALU_OR;
            default: return isa_pkg::ALU_AND;
        endcase
    endfunction

    function automatic logic [3:0] branch_of(input logic [2:0] f3);
        case (f3)
            3'h1: return isa_pkg::BR_NE;
            3'h4: return isa_pkg::BR_LT;
            3'h5: return isa_pkg::BR_GE;
            3'h6: return isa_pkg::BR_LTU;
            3'h7: return isa_pkg::BR_GEU;
            default: return isa_pkg::BR_EQ;
        endcase
    endfunction

    function automatic logic [3:0] system_of(input logic [11:0] f12);
        case (f12)
            12'h001: return isa_pkg::BR_EBREAK;
            12'h002: return isa_pkg::BR_URET;
            12'h102: return isa_pkg::BR_SRET;
            12'h302: return isa_pkg::BR_MRET;
            default: return isa_pkg::BR_ECALL;
        endcase
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic stall_of(input isa_pkg::instr_t in);
        case (in[6:0])
            isa_pkg::OP_JAL, isa_pkg::OP_JALR, isa_pkg::OP_B, isa_pkg::OP_SYS: return 1'b1;
            isa_pkg::OP_EXT1: return in[31:25] == 7'h00 && in[14:12] <= 3'h5;
            default: return 1'b0;
        endcase
    endfunction

    // Expected micro-op body from the instruction encoding
    function automatic decode_pkg::uop_body_t ref_body(input isa_pkg::instr_t in);
        decode_pkg::uop_body_t b;
        logic [2:0]            f3;
        logic                  wr;
        b  = '0;
        f3 = in[14:12];
        wr = 1'b0;
        b.ex_type = decode_pkg::EX_ALU;
        case (in[6:0])
            isa_pkg::OP_I: begin
                b.op_type = alu_of(f3, in[30], 1'b0);
                b.use_imm = 1'b1;
                b.imm = (f3 == 3'h1 || f3 == 3'h5) ? {27'b0, in[24:20]} : sext12(in[31:20]);
                b.rs1 = in[19:15];
                wr = 1'b1;
            end
            isa_pkg::OP_R: begin
                b.op_type = alu_of(f3, in[30], 1'b1);
                b.rs1 = in[19:15];
                b.rs2 = in[24:20];
                wr = 1'b1;
            end
            isa_pkg::OP_LUI, isa_pkg::OP_AUIPC: begin
                b.op_type = (in[6:0] == isa_pkg::OP_LUI) ? isa_pkg::ALU_LUI : isa_pkg::ALU_AUIPC;
                b.use_pc  = (in[6:0] == isa_pkg::OP_AUIPC);
                b.use_imm = 1'b1;
                b.imm = {in[31:12], 12'b0};
                wr = 1'b1;
            end
            isa_pkg::OP_JAL: begin
                b.op_type = isa_pkg::BR_JAL;
                {b.is_br, b.use_pc, b.use_imm} = 3'b111;
                b.imm = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
                wr = 1'b1;
            end
            isa_pkg::OP_JALR: begin
                b.op_type = isa_pkg::BR_JALR;
                {b.is_br, b.use_imm} = 2'b11;
                b.imm = sext12(in[31:20]);
                b.rs1 = in[19:15];
                wr = 1'b1;
            end
            isa_pkg::OP_B: begin
                b.op_type = branch_of(f3);
                {b.is_br, b.use_pc, b.use_imm} = 3'b111;
                b.imm = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
                b.rs1 = in[19:15];
                b.rs2 = in[24:20];
            end
            isa_pkg::OP_L, isa_pkg::OP_S: begin
                b.ex_type = decode_pkg::EX_LSU;
                b.op_type = {in[6:0] == isa_pkg::OP_S, f3};
                b.use_imm = 1'b1;
                b.rs1 = in[19:15];
                if (in[6:0] == isa_pkg::OP_S) begin
                    b.imm = sext12({in[31:25], in[11:7]});
                    b.rs2 = in[24:20];
                end else begin
                    b.imm = sext12(in[31:20]);
                    wr = 1'b1;
                end
            end
            isa_pkg::OP_FENCE: begin
                b.ex_type = decode_pkg::EX_LSU;
                b.op_type = isa_pkg::LSU_FENCE;
            end
            isa_pkg::OP_SYS: begin
                wr = 1'b1;
                if (f3[1:0] == 2'b00) begin
                    b.op_type = system_of(in[31:20]);
                    {b.is_br, b.use_pc, b.use_imm} = 3'b111;
                    b.imm = 32'd4;
                end else begin
                    b.ex_type = decode_pkg::EX_SFU;
                    b.op_type = (f3[1:0] == 2'b01) ? isa_pkg::SFU_CSRRW :
                                (f3[1:0] == 2'b10) ? isa_pkg::SFU_CSRRS : isa_pkg::SFU_CSRRC;
                    b.use_imm = f3[2];
                    b.imm[11:0] = in[31:20];
                    if (f3[2]) b.imm[16:12] = in[19:15];
                    else b.rs1 = in[19:15];
                end
            end
            isa_pkg::OP_EXT1: begin
                if (stall_of(in)) begin
                    b.ex_type = decode_pkg::EX_SFU;
                    b.op_type = {1'b0, f3}; // TMC is 0 up to PRED at 5
                    b.rs1 = in[19:15];
                    if (f3 == 3'h1 || f3 == 3'h4 || f3 == 3'h5) b.rs2 = in[24:20];
                    wr = (f3 == 3'h2);
                end
            end
            default: ;
        endcase
        b.rd = wr ? in[11:7] : 5'd0;
        b.wb = wr && in[11:7] != 5'd0;
        return b;
    endfunction

    // Legal RV32I and warp-control words with random fields
    function automatic isa_pkg::instr_t rand_instr();
        isa_pkg::instr_t r;
        int              k;
        r = $urandom;
        k = $urandom_range(0, 9);
        case (k)
            0: begin
                r[6:0] = isa_pkg::OP_R;
                r[31:25] = ((r[14:12] == 0 || r[14:12] == 5) && r[30]) ? 7'h20 : 7'h00;
            end
            1: begin
                r[6:0] = isa_pkg::OP_I;
                if (r[14:12] == 1) r[31:25] = 7'h00;
                if (r[14:12] == 5) r[31:25] = {1'b0, r[30], 5'b0};
            end
            2: r[6:0] = r[31] ? isa_pkg::OP_LUI : isa_pkg::OP_AUIPC;
            3: r[6:0] = isa_pkg::OP_JAL;
            4: begin
                r[6:0] = isa_pkg::OP_JALR;
                r[14:12] = 3'h0;
            end
            5: begin
                r[6:0] = isa_pkg::OP_B;
                if (r[14:13] == 2'b01) r[13] = 1'b0;
            end
            6: begin
                r[6:0] = isa_pkg::OP_L;
                if (r[14:12] == 3) r[14:12] = 3'h2;
                if (r[14:12] >= 6) r[14:12] = r[14:12] - 3'h2;
            end
            7: begin
                r[6:0] = isa_pkg::OP_S;
                r[14] = 1'b0;
                if (r[13:12] == 2'b11) r[12] = 1'b0;
            end
            8: begin
                r[6:0] = isa_pkg::OP_SYS;
                if (r[13:12] == 2'b00) begin
                    r[31:7] = '0;
                    r[31:20] = ($urandom_range(0, 1) != 0) ? 12'h302 : 12'h001;
                end
            end
            default: begin
                r[6:0] = isa_pkg::OP_EXT1;
                r[31:25] = 7'h00;
                r[14:12] = 3'($urandom_range(0, 5));
            end
        endcase
        return r;
    endfunction

    // Output side pops, accept side pushes
    always @(posedge clk) begin
        if (!reset) begin
            if (uop_valid && uop_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: a uop came out with no packet waiting for it", test_name);
                    errors++;
                end else begin
                    exp_head = exp_q.pop_front();
                    checks++;
                    if (uop !== exp_head) begin
                        $display("[FAIL] %s expected %h actual %h", test_name, exp_head, uop);
                        errors++;
                    end
                end
            end
            if (fetch_valid && fetch_ready) begin
                exp_q.push_back({fetch.wid, fetch.tmask, fetch.pc, ref_body(fetch.instr)});
                checks++;
                if (sched !== {fetch.wid, stall_of(fetch.instr)}) begin
                    $display("[FAIL] %s sched expected %h actual %h", test_name,
                             {fetch.wid, stall_of(fetch.instr)}, sched);
                    errors++;
                end
            end
        end
    end

    task automatic load_packet(input isa_pkg::instr_t in);
        fetch.wid   = 2'($urandom);
        fetch.tmask = 4'($urandom);
        fetch.pc    = $urandom & 32'hffff_fffc;
        fetch.instr = in;
        fetch_valid = 1'b1;
    endtask

    task automatic send(input isa_pkg::instr_t in);
        logic acc;
        acc = 1'b0;
        load_packet(in);
        for (int t = 0; t < 50 && !acc; t++) begin
            @(negedge clk);
            acc = fetch_ready;
            @(posedge clk);
            #2;
        end
        fetch_valid = 1'b0;
        if (!acc) begin
            $display("%s: fetch_ready never rose for instruction %h", test_name, in);
            errors++;
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 100) begin
            @(posedge clk);
            t++;
        end
        #2;
        if (exp_q.size() != 0) begin
            $display("%s: %0d uops never left the stage", test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done with %0d errors", test_name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        int  sent;
        int  cyc;
        logic acc;
        void'($urandom(32'h5b43b9f0));
        reset       = 1'b1;
        fetch_valid = 1'b0;
        uop_ready   = 1'b1;
        fetch       = '0;

        test_name = "reset";
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #2;
            if (i == 4) reset = 1'b0;
            if (uop_valid !== 1'b0) begin
                $display("[FAIL] %s expected 0 actual %b", test_name, uop_valid);
                errors++;
            end
        end
        end_test();

        test_name = "alu";
        send(32'h003100b3); // add x1,x2,x3
        send(32'h407302b3); // sub
        send(32'h40a4d433); // sra
        send(32'h00208033); // add x0 gives no wb
        send(32'hffb10093);
        send(32'h40008093); // addi with bit 30 set stays ADD
        send(32'h40725193); // srai
        send(32'h01f21193);
        send(32'h123452b7);
        send(32'hfffff317);
        drain();
        end_test();

        test_name = "control";
        send(32'h00208463);
        send(32'hfe209ee3);
        send(32'h0020e463);
        send(32'h010000ef);
        send(32'h004100e7);
        send(32'h00000073);
        send(32'h00100073);
        send(32'h00200073);
        send(32'h10200073);
        send(32'h30200073);
        drain();
        end_test();

        test_name = "memory_csr";
        send(32'h0080a283);
        send(32'h0040c283);
        send(32'h0050a623);
        send(32'hfe218fa3);
        send(32'h0ff0000f);
        send(32'h300110f3);
        send(32'h3412e1f3);
        send(32'hc0023073);
        drain();
        end_test();

        test_name = "warp_control";
        send(32'h0000810b); // tmc, rd field set but not written
        send(32'h0020900b);
        send(32'h0002218b);
        send(32'h0002b00b);
        send(32'h0020c28b); // bar with rd field x5
        send(32'h0020d00b);
        drain();
        end_test();

        // Packet held stable until taken
        test_name = "random";
        sent = 0;
        cyc  = 0;
        while (sent < 200 && cyc < 5000) begin
            uop_ready = ($urandom % 4) != 0;
            if (!fetch_valid && ($urandom % 3) != 0) load_packet(rand_instr());
            @(negedge clk);
            acc = fetch_valid && fetch_ready;
            @(posedge clk);
            #2;
            cyc++;
            if (acc) begin
                fetch_valid = 1'b0;
                sent++;
            end
        end
        fetch_valid = 1'b0;
        uop_ready   = 1'b1;
        if (sent < 200) begin
            $display("%s: only %0d of 200 packets were accepted in time", test_name, sent);
            errors++;
        end
        drain();
        end_test();

        errors = errors + DUT.u_chk.fail_count;
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 tests, checks, DUT.u_chk.fail_count, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
source/isa_pkg.sv
source/decode_pkg.sv
source/imm_gen.sv
source/op_tables.sv
source/instr_decoder.sv
source/decode_pipe_reg.sv
source/decode_top.sv
bench/decode_chk.sv
bench/decode_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; the log decides the result
verilator --binary --timing --assert -f compile.f --top-module decode_tb -o decode_sim \
    && ./obj_dir/decode_sim +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log \
    && grep -q "sim passed" sim.log && ! grep -q "sim failed" sim.log \
    || { echo "simulation failed"; exit 1; }
